//--- sim.f
common/arrayMemPkg.sv
common/elemBusIf.sv
hw/arrayTable/arrayTable.sv
hw/elementStore/elementStore.sv
hw/arrayMemTop.sv
dv/arrayMem_checker.sv
dv/arrayMemTb.sv

//--- Makefile
# Verilator build and run for the array memory testbench

VERILATOR ?= verilator
TOP       ?= arrayMemTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/arrayMemTb.sv
//////////////////////////////////////////////////////////////////////
// Array memory testbench: LFSR commands checked against a model
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module arrayMemTb;

  localparam int addrBits     = 3;
  localparam int indexBits    = 3;
  localparam int dataBits     = 16;
  localparam int arrays       = 2**addrBits;
  localparam int arrayLength  = 2**indexBits;
  localparam int commandCount = 1500;
  localparam int resetCycles  = 16;
  localparam int cycleLimit   = commandCount + resetCycles + 100;

  logic                  clock;
  logic                  rstN;
  arrayMemPkg::arrayOpT  action;
  logic [addrBits-1:0]   array;
  logic [indexBits-1:0]  index;
  logic [dataBits-1:0]   dataIn;
  logic [dataBits-1:0]   result;
  arrayMemPkg::arrayErrT errorCode;
  logic                  done;

  logic [15:0]           lfsrState;
  int                    cycleCount = 0;
  int                    mismatchCount = 0;
  int                    protocolCount = 0;

  // Model state
  bit                    allocated [arrays];
  int                    sizes     [arrays];
  int                    usedCount;
  int                    freeStack [$];
  logic [dataBits-1:0]   mem       [arrays][arrayLength];
  bit                    known     [arrays][arrayLength];  // Element ever written

  logic [dataBits-1:0]   expResult [$];
  arrayMemPkg::arrayErrT expErr    [$];
  bit                    expValued [$];                    // Result value is defined

  arrayMemTop #(
    .addrBits  (addrBits),
    .indexBits (indexBits),
    .dataBits  (dataBits)
  ) i_arrayMemTop (
    .clock     (clock),
    .rstN      (rstN),
    .action    (action),
    .array     (array),
    .index     (index),
    .dataIn    (dataIn),
    .result    (result),
    .errorCode (errorCode),
    .done      (done)
  );

  always #4 clock = ~clock;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
      feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
      lfsrState = {lfsrState[14:0], feedback};
      value     = {value[30:0], feedback};
    end
    return value;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    if (got !== expected) begin
      mismatchCount++;
      $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, expected, $time);
    end
  endtask

  task automatic pickCommand(output arrayMemPkg::arrayOpT op, output int arr,
                             output int idx, output logic [dataBits-1:0] data);
    logic [3:0] pick;
    pick = 4'(takeBits(4));
    case (pick)
      0, 1:    op = arrayMemPkg::opNop;
      2:       op = arrayMemPkg::opAlloc;
      3:       op = arrayMemPkg::opFree;
      4, 5:    op = arrayMemPkg::opWrite;
      6, 15:   op = arrayMemPkg::opRead;
      7:       op = arrayMemPkg::opSize;
      8:       op = arrayMemPkg::opPush;
      9:       op = arrayMemPkg::opPop;
      10:      op = arrayMemPkg::opAdd;
      11:      op = arrayMemPkg::opSub;
      12:      op = arrayMemPkg::opOr;
      13:      op = arrayMemPkg::opXor;
      default: op = arrayMemPkg::opAnd;
    endcase
    arr  = takeBits(1) ? int'(takeBits(2)) : int'(takeBits(addrBits));  // Favor low arrays
    idx  = int'(takeBits(indexBits));
    data = dataBits'(takeBits(dataBits));
  endtask

  task automatic modelCommand(input arrayMemPkg::arrayOpT op, input int arr, input int idx,
                              input logic [dataBits-1:0] data);
    arrayMemPkg::arrayErrT err;
    logic [dataBits-1:0]   res;
    bit                    valued;
    int                    size;
    res    = '0;
    valued = 1'b1;
    size   = sizes[arr];
    if (arr >= usedCount)    err = arrayMemPkg::errNotAllocated;
    else if (!allocated[arr]) err = arrayMemPkg::errFreed;
    else                      err = arrayMemPkg::errNone;
    if (err == arrayMemPkg::errNone && idx >= size && op inside {arrayMemPkg::opRead,
        arrayMemPkg::opAdd, arrayMemPkg::opSub, arrayMemPkg::opOr, arrayMemPkg::opXor,
        arrayMemPkg::opAnd})
      err = arrayMemPkg::errOutOfBounds;
    if (op == arrayMemPkg::opPush && err == arrayMemPkg::errNone && size == arrayLength)
      err = arrayMemPkg::errFull;
    if (op == arrayMemPkg::opPop && err == arrayMemPkg::errNone && size == 0)
      err = arrayMemPkg::errEmpty;
    if (op == arrayMemPkg::opAlloc) begin
      err = arrayMemPkg::errNone;                     // Array input is ignored
      if (freeStack.size() != 0) begin
        res = dataBits'(freeStack.pop_back());       // Last freed comes back first
      end else if (usedCount < arrays) begin
        res = dataBits'(usedCount);
        usedCount++;
      end else begin
        err = arrayMemPkg::errNoMemory;
      end
      if (err == arrayMemPkg::errNone) begin
        allocated[res] = 1'b1;
        sizes[res]     = 0;
      end
    end else if (err == arrayMemPkg::errNone) begin
      case (op)
        arrayMemPkg::opFree: begin
          allocated[arr] = 1'b0;
          freeStack.push_back(arr);
        end
        arrayMemPkg::opWrite, arrayMemPkg::opPush: begin
          if (op == arrayMemPkg::opPush) idx = size;
          mem[arr][idx]   = data;
          known[arr][idx] = 1'b1;
          if (idx >= size) sizes[arr] = idx + 1;
          res = data;
        end
        arrayMemPkg::opSize: res = dataBits'(size);
        arrayMemPkg::opRead, arrayMemPkg::opPop: begin
          if (op == arrayMemPkg::opPop) begin
            idx        = size - 1;
            sizes[arr] = size - 1;
          end
          res    = mem[arr][idx];
          valued = known[arr][idx];
        end
        default: begin
          case (op)
            arrayMemPkg::opAdd: res = mem[arr][idx] + data;   // Wraps at dataBits
            arrayMemPkg::opSub: res = mem[arr][idx] - data;
            arrayMemPkg::opOr:  res = mem[arr][idx] | data;
            arrayMemPkg::opXor: res = mem[arr][idx] ^ data;
            default:            res = mem[arr][idx] & data;
          endcase
          if (known[arr][idx]) mem[arr][idx] = res;
          else                 valued = 1'b0;
        end
      endcase
    end
    if (err != arrayMemPkg::errNone) res = '0;
    expResult.push_back(res);
    expErr.push_back(err);
    expValued.push_back(valued);
  endtask

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout after %0d cycles, %0d results still outstanding",
               cycleCount, expResult.size());
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // Outputs settle after the rising edge, so compare on the falling edge
  always @(negedge clock) begin
    if (done) begin
      if (expResult.size() == 0) begin
        protocolCount++;
        $display("Done was raised at %0t with no command outstanding", $time);
      end else begin
        checkValue("errorCode", 32'(errorCode), 32'(expErr.pop_front()));
        if (expValued.pop_front()) checkValue("result", 32'(result), 32'(expResult[0]));
        void'(expResult.pop_front());
      end
    end
  end

  initial begin
    arrayMemPkg::arrayOpT op;
    int                   arr;
    int                   idx;
    logic [dataBits-1:0]  data;
    clock     = 1'b0;
    rstN      = 1'b0;
    action    = arrayMemPkg::opNop;
    array     = '0;
    index     = '0;
    dataIn    = '0;
    lfsrState = 16'd39;
    usedCount = 0;
    repeat (resetCycles) @(posedge clock);
    rstN <= 1'b1;
    for (int n = 0; n < commandCount; n++) begin
      @(posedge clock);
      pickCommand(op, arr, idx, data);
      action <= op;
      array  <= addrBits'(arr);
      index  <= indexBits'(idx);
      dataIn <= data;
      if (op != arrayMemPkg::opNop) modelCommand(op, arr, idx, data);
    end
    @(posedge clock);
    action <= arrayMemPkg::opNop;
    while (expResult.size() != 0) @(posedge clock);
    @(negedge clock);
    $display("Errors: %0d mismatches, %0d protocol, %0d assertion", mismatchCount,
             protocolCount, i_arrayMemTop.i_checker.failCount);
    if (mismatchCount == 0 && protocolCount == 0 && i_arrayMemTop.i_checker.failCount == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- dv/arrayMem_checker.sv
//////////////////////////////////////////////////////////////////////
// Array memory checker: command to done timing, error results, reset
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module arrayMem_checker #(
  parameter int dataBits = 16
) (
  input logic                  clock,
  input logic                  rstN,
  input arrayMemPkg::arrayOpT  action,
  input logic [dataBits-1:0]   result,
  input arrayMemPkg::arrayErrT errorCode,
  input logic                  done
);

  int failCount = 0;                  // Assertion failures so far

  commandGivesDone: assert property (@(posedge clock) disable iff (!rstN)
    $past(action != arrayMemPkg::opNop, arrayMemPkg::pipeLatency) |-> done)
    else begin
      failCount++;
      $error("Command was not followed by done at the fixed latency");
    end

  doneNeedsCommand: assert property (@(posedge clock) disable iff (!rstN)
    done |-> $past(action != arrayMemPkg::opNop, arrayMemPkg::pipeLatency))
    else begin
      failCount++;
      $error("Done was raised without a command at the fixed latency");
    end

  errorGivesZero: assert property (@(posedge clock) disable iff (!rstN)
    (done && errorCode != arrayMemPkg::errNone) |-> (result == '0))
    else begin
      failCount++;
      $error("Failed command returned a nonzero result");
    end

  // Sync reset clears done one edge later
  quietInReset: assert property (@(posedge clock) !rstN |=> !done)
    else begin
      failCount++;
      $error("Done was high during reset");
    end

endmodule

bind arrayMemTop arrayMem_checker #(.dataBits(dataBits)) i_checker (
  .clock     (clock),
  .rstN      (rstN),
  .action    (action),
  .result    (result),
  .errorCode (errorCode),
  .done      (done)
);

//--- hw/arrayMemTop.sv
//////////////////////////////////////////////////////////////////////
// Array memory top level: array table stage feeding the element
// store stage, result arrayMemPkg::pipeLatency cycles after command
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module arrayMemTop #(
  parameter int addrBits  = 3,        // Arrays are numbered 0 to 2**addrBits-1
  parameter int indexBits = 3,        // Each array holds 2**indexBits elements
  parameter int dataBits  = 16        // Element width
) (
  input  logic                   clock,
  input  logic                   rstN,
  input  arrayMemPkg::arrayOpT   action,    // One command per cycle
  input  logic [addrBits-1:0]    array,     // Target array
  input  logic [indexBits-1:0]   index,     // Element within the array
  input  logic [dataBits-1:0]    dataIn,    // Operand
  output logic [dataBits-1:0]    result,    // Command result
  output arrayMemPkg::arrayErrT  errorCode, // Command outcome
  output logic                   done       // Result and errorCode valid
);

  elemBusIf #(
    .addrBits  (addrBits),
    .indexBits (indexBits),
    .dataBits  (dataBits)
  ) elemBus ();

  // Stage one, allocation and legality
  arrayTable #(
    .addrBits  (addrBits),
    .indexBits (indexBits),
    .dataBits  (dataBits)
  ) i_arrayTable (
    .clock   (clock),
    .rstN    (rstN),
    .action  (action),
    .array   (array),
    .index   (index),
    .dataIn  (dataIn),
    .elemBus (elemBus.tableSide)
  );

  // Stage two, element memory
  elementStore #(
    .addrBits  (addrBits),
    .indexBits (indexBits),
    .dataBits  (dataBits)
  ) i_elementStore (
    .clock     (clock),
    .rstN      (rstN),
    .elemBus   (elemBus.storeSide),
    .result    (result),
    .errorCode (errorCode),
    .done      (done)
  );

endmodule

//--- hw/elementStore/elementStore.sv
//////////////////////////////////////////////////////////////////////
// Element store: flop array of all elements, performs read, write
// and read-modify-write, registers the command result
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module elementStore #(
  parameter int addrBits  = 3,
  parameter int indexBits = 3,
  parameter int dataBits  = 16
) (
  input  logic                   clock,
  input  logic                   rstN,
  elemBusIf.storeSide            elemBus,
  output logic [dataBits-1:0]    result,
  output arrayMemPkg::arrayErrT  errorCode,
  output logic                   done
);

  localparam int arrays      = 2**addrBits;
  localparam int arrayLength = 2**indexBits;

  logic [dataBits-1:0] memory [arrays][arrayLength];  // Fixed block per array

  logic [dataBits-1:0] oldValue;                      // Element before the op
  logic [dataBits-1:0] newValue;                      // Element after, or pass data
  logic                doAccess;                      // Legal request this cycle
  logic                isModify;                      // Op stores into memory
  logic                writeEn;

  always_comb begin
    oldValue = memory[elemBus.array][elemBus.index];
    isModify = 1'b1;
    case (elemBus.op)
      arrayMemPkg::elemWrite: newValue = elemBus.data;
      arrayMemPkg::elemAdd:   newValue = oldValue + elemBus.data;  // Wraps at dataBits
      arrayMemPkg::elemSub:   newValue = oldValue - elemBus.data;
      arrayMemPkg::elemOr:    newValue = oldValue | elemBus.data;
      arrayMemPkg::elemXor:   newValue = oldValue ^ elemBus.data;
      arrayMemPkg::elemAnd:   newValue = oldValue & elemBus.data;
      arrayMemPkg::elemRead: begin
        newValue = oldValue;
        isModify = 1'b0;
      end
      arrayMemPkg::elemPass: begin
        newValue = elemBus.data;                      // Size or allocated array
        isModify = 1'b0;
      end
      default: begin
        newValue = '0;                                // Free gives zero
        isModify = 1'b0;
      end
    endcase
    doAccess = elemBus.valid && (elemBus.err == arrayMemPkg::errNone);
    writeEn  = doAccess && isModify;
  end

  // Written at the end of the request cycle, so the next request sees it
  always_ff @(posedge clock) begin
    if (writeEn) memory[elemBus.array][elemBus.index] <= newValue;
  end

  always_ff @(posedge clock) begin
    if (!rstN) begin
      done      <= 1'b0;
      result    <= '0;
      errorCode <= arrayMemPkg::errNone;
    end else begin
      done      <= elemBus.valid;
      result    <= doAccess ? newValue : '0;          // Zero on any error
      errorCode <= elemBus.valid ? elemBus.err : arrayMemPkg::errNone;
    end
  end

endmodule

//--- hw/arrayTable/arrayTable.sv
//////////////////////////////////////////////////////////////////////
// Array table: allocation flags, sizes and the LIFO free stack
// Checks every command and issues one element request per command
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module arrayTable #(
  parameter int addrBits  = 3,
  parameter int indexBits = 3,
  parameter int dataBits  = 16
) (
  input  logic                  clock,
  input  logic                  rstN,
  input  arrayMemPkg::arrayOpT  action,
  input  logic [addrBits-1:0]   array,
  input  logic [indexBits-1:0]  index,
  input  logic [dataBits-1:0]   dataIn,
  elemBusIf.tableSide           elemBus
);

  localparam int arrays      = 2**addrBits;
  localparam int arrayLength = 2**indexBits;

  logic                  allocated [arrays];   // Array currently in use
  logic [indexBits:0]    sizes     [arrays];   // Elements in each array
  logic [addrBits-1:0]   freeStack [arrays];   // Freed arrays, last on top
  logic [addrBits:0]     usedCount;            // Arrays ever handed out
  logic [addrBits:0]     freeTop;              // Entries on the free stack

  logic [indexBits:0]    curSize;
  logic [indexBits:0]    sizeUp;
  logic [indexBits:0]    sizeDown;
  logic [indexBits:0]    writeSize;            // Size implied by a write
  logic [addrBits:0]     stackTop;
  logic                  canAlloc;
  logic [addrBits-1:0]   allocArray;           // Array the next alloc gets
  arrayMemPkg::arrayErrT accessErr;            // Array usable at all
  arrayMemPkg::arrayErrT readErr;              // Plus index inside size

  logic                  isCmd;
  logic                  commit;               // Command changes state
  arrayMemPkg::elemOpT   nextOp;
  logic [indexBits-1:0]  nextIndex;
  logic [dataBits-1:0]   nextData;
  arrayMemPkg::arrayErrT nextErr;

  always_comb begin
    curSize    = sizes[array];
    sizeUp     = curSize + 1'b1;
    sizeDown   = curSize - 1'b1;
    writeSize  = {1'b0, index} + 1'b1;
    stackTop   = freeTop - 1'b1;
    canAlloc   = (freeTop != '0) || (usedCount < (addrBits+1)'(arrays));
    allocArray = (freeTop != '0) ? freeStack[stackTop[addrBits-1:0]]
                                 : usedCount[addrBits-1:0];   // Reuse before new

    // Arrays below usedCount were handed out once, so a clear flag means freed
    if ({1'b0, array} >= usedCount) accessErr = arrayMemPkg::errNotAllocated;
    else if (!allocated[array])     accessErr = arrayMemPkg::errFreed;
    else                            accessErr = arrayMemPkg::errNone;

    if (accessErr == arrayMemPkg::errNone && {1'b0, index} >= curSize)
      readErr = arrayMemPkg::errOutOfBounds;
    else
      readErr = accessErr;

    isCmd     = 1'b1;
    nextOp    = arrayMemPkg::elemNone;
    nextIndex = index;
    nextData  = dataIn;
    nextErr   = accessErr;

    case (action)
      arrayMemPkg::opAlloc: begin
        nextOp   = arrayMemPkg::elemPass;
        nextData = dataBits'(allocArray);                     // Array number out
        nextErr  = canAlloc ? arrayMemPkg::errNone : arrayMemPkg::errNoMemory;
      end
      arrayMemPkg::opFree:  nextOp = arrayMemPkg::elemNone;  // Result is zero
      arrayMemPkg::opWrite: nextOp = arrayMemPkg::elemWrite;
      arrayMemPkg::opRead: begin
        nextOp  = arrayMemPkg::elemRead;
        nextErr = readErr;
      end
      arrayMemPkg::opSize: begin
        nextOp   = arrayMemPkg::elemPass;
        nextData = dataBits'(curSize);
      end
      arrayMemPkg::opPush: begin
        nextOp    = arrayMemPkg::elemWrite;
        nextIndex = curSize[indexBits-1:0];                   // First free slot
        if (accessErr == arrayMemPkg::errNone && curSize == (indexBits+1)'(arrayLength))
          nextErr = arrayMemPkg::errFull;
      end
      arrayMemPkg::opPop: begin
        nextOp    = arrayMemPkg::elemRead;
        nextIndex = sizeDown[indexBits-1:0];                  // Last element
        if (accessErr == arrayMemPkg::errNone && curSize == '0)
          nextErr = arrayMemPkg::errEmpty;
      end
      arrayMemPkg::opAdd: begin
        nextOp  = arrayMemPkg::elemAdd;
        nextErr = readErr;
      end
      arrayMemPkg::opSub: begin
        nextOp  = arrayMemPkg::elemSub;
        nextErr = readErr;
      end
      arrayMemPkg::opOr: begin
        nextOp  = arrayMemPkg::elemOr;
        nextErr = readErr;
      end
      arrayMemPkg::opXor: begin
        nextOp  = arrayMemPkg::elemXor;
        nextErr = readErr;
      end
      arrayMemPkg::opAnd: begin
        nextOp  = arrayMemPkg::elemAnd;
        nextErr = readErr;
      end
      default: isCmd = 1'b0;                                  // Nop or unused code
    endcase
  end

  assign commit = isCmd && (nextErr == arrayMemPkg::errNone);

  always_ff @(posedge clock) begin
    if (!rstN) begin
      elemBus.valid <= 1'b0;
      usedCount     <= '0;
      freeTop       <= '0;
      for (int i = 0; i < arrays; i++) allocated[i] <= 1'b0;
    end else begin
      elemBus.valid <= isCmd;
      if (commit) begin
        case (action)
          arrayMemPkg::opAlloc: begin
            allocated[allocArray] <= 1'b1;
            if (freeTop != '0) freeTop   <= stackTop;           // Pop the free stack
            else               usedCount <= usedCount + 1'b1;   // Fresh array
          end
          arrayMemPkg::opFree: begin
            allocated[array] <= 1'b0;
            freeTop          <= freeTop + 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    elemBus.op    <= nextOp;
    elemBus.array <= array;
    elemBus.index <= nextIndex;
    elemBus.data  <= nextData;
    elemBus.err   <= nextErr;
    if (commit) begin
      case (action)
        arrayMemPkg::opAlloc: sizes[allocArray] <= '0;      // Starts empty
        arrayMemPkg::opFree:  freeStack[freeTop[addrBits-1:0]] <= array;
        arrayMemPkg::opWrite: if (writeSize > curSize) sizes[array] <= writeSize;
        arrayMemPkg::opPush:  sizes[array] <= sizeUp;
        arrayMemPkg::opPop:   sizes[array] <= sizeDown;
        default: ;
      endcase
    end
  end

endmodule

//--- common/elemBusIf.sv
//////////////////////////////////////////////////////////////////////
// Element request bus from the array table to the element store
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface elemBusIf #(
  parameter int addrBits  = 3,
  parameter int indexBits = 3,
  parameter int dataBits  = 16
);

  logic                  valid;       // One cycle request strobe
  arrayMemPkg::elemOpT   op;          // What the store has to do
  logic [addrBits-1:0]   array;       // Element address, array part
  logic [indexBits-1:0]  index;       // Element address, index part
  logic [dataBits-1:0]   data;        // Operand or forwarded result
  arrayMemPkg::arrayErrT err;         // Verdict of the table stage

  modport tableSide (
    output valid, op, array, index, data, err
  );

  modport storeSide (
    input valid, op, array, index, data, err
  );

endinterface

//--- common/arrayMemPkg.sv
//////////////////////////////////////////////////////////////////////
// Array memory shared types: command opcodes, element stage
// operations, error codes and the fixed pipeline latency
//////////////////////////////////////////////////////////////////////
package arrayMemPkg;

  // Command to result latency in clock cycles
  localparam int pipeLatency = 2;

  // Caller commands on the action bus
  typedef enum logic [7:0] {
    opNop   = 8'd0,                   // No command this cycle
    opWrite = 8'd2,                   // Write an element, grow size
    opRead  = 8'd3,                   // Bounds checked read
    opSize  = 8'd4,                   // Current size of an array
    opPush  = 8'd14,                  // Append at the end
    opPop   = 8'd15,                  // Remove from the end
    opAlloc = 8'd18,                  // Allocate an array
    opFree  = 8'd19,                  // Return an array for reuse
    opAdd   = 8'd20,                  // Add, return new value
    opSub   = 8'd22,                  // Subtract, return new value
    opOr    = 8'd28,                  // Bitwise or
    opXor   = 8'd29,                  // Bitwise xor
    opAnd   = 8'd30                   // Bitwise and
  } arrayOpT;

  // Work handed from the array table to the element store
  // Nine operations need a four bit code
  typedef enum logic [3:0] {
    elemNone,                         // Nothing to do, result zero
    elemRead,                         // Return the element
    elemWrite,                        // Store the operand
    elemAdd,                          // Element plus operand
    elemSub,                          // Element minus operand
    elemOr,                           // Element or operand
    elemXor,                          // Element xor operand
    elemAnd,                          // Element and operand
    elemPass                          // Forward the table result
  } elemOpT;

  // Outcome of a command
  typedef enum logic [2:0] {
    errNone,                          // Command succeeded
    errNotAllocated,                  // Array never handed out
    errFreed,                         // Array was freed
    errOutOfBounds,                   // Index at or past the size
    errFull,                          // Push on a full array
    errEmpty,                         // Pop on an empty array
    errNoMemory                       // No array left to allocate
  } arrayErrT;

endpackage
